// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      instr_valid,
    input  mini_mips_pkg::word_t     instr,
    reg_read_bus.reader              rd,
    input  wire                      fwd_en,
    input  mini_mips_pkg::reg_addr_t fwd_addr,
    input  mini_mips_pkg::word_t     fwd_data,
    exec_bus.source                  ex
);
    import mini_mips_pkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs_idx;
    reg_addr_t  rt_idx;
    reg_addr_t  rd_idx;
    shamt_t     shamt;
    logic [15:0] imm;

    alu_op_t    alu_op;
    reg_addr_t  dest;
    logic       known;
    logic       is_shift;
    logic       imm_signed;
    word_t      rs_val;
    word_t      rt_val;
    word_t      imm_ext;
    word_t      op_a;
    word_t      op_b;

    // execute-stage result wins, r0 never forwarded
    function automatic word_t pick_src(input reg_addr_t idx, input word_t file_val);
        if (fwd_en && idx != '0 && fwd_addr == idx) begin
            return fwd_data;
        end
        return file_val;
    endfunction

    assign opcode = instr[31:26];
    assign rs_idx = instr[25:21];
    assign rt_idx = instr[20:16];
    assign rd_idx = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];
    assign imm    = instr[15:0];

    assign rd.rs_addr = rs_idx;
    assign rd.rt_addr = rt_idx;
    assign rs_val = pick_src(rs_idx, rd.rs_data);
    assign rt_val = pick_src(rt_idx, rd.rt_data);

    always_comb begin
        alu_op     = ALU_ADD;
        dest       = rt_idx;
        known      = 1'b1;
        is_shift   = 1'b0;
        imm_signed = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dest = rd_idx;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL: begin
                        alu_op   = ALU_SLL;
                        is_shift = 1'b1;
                    end
                    FN_SRL: begin
                        alu_op   = ALU_SRL;
                        is_shift = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                alu_op     = ALU_ADD;
                imm_signed = 1'b1;
            end
            OP_SLTI: begin
                alu_op     = ALU_SLT;
                imm_signed = 1'b1;
            end
            OP_ANDI: alu_op = ALU_AND;
            OP_ORI:  alu_op = ALU_OR;
            OP_XORI: alu_op = ALU_XOR;
            OP_LUI:  alu_op = ALU_LUI;
            default: known = 1'b0;
        endcase
    end

    assign imm_ext = imm_signed ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    // shifts take rt as the value and shamt as the amount
    assign op_a = is_shift ? rt_val : rs_val;
    assign op_b = is_shift ? word_t'(shamt) :
                  (opcode == OP_RTYPE) ? rt_val : imm_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid <= 1'b0;
        end else begin
            ex.valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex.alu_op    <= alu_op;
            ex.dest      <= dest;
            ex.write_en  <= known && (dest != '0);
            ex.operand_a <= op_a;
            ex.operand_b <= op_b;
        end
    end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                       clk,
    input  wire                       rst,
    exec_bus.sink                     ex,
    output logic                      fwd_en,
    output mini_mips_pkg::reg_addr_t  fwd_addr,
    output mini_mips_pkg::word_t      fwd_data,
    output logic                      wb_valid,
    output mini_mips_pkg::reg_addr_t  wb_addr,
    output mini_mips_pkg::word_t      wb_data
);
    import mini_mips_pkg::*;

    word_t  result;
    shamt_t sh;
    logic   do_write;

    assign sh = ex.operand_b[4:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:  result = ex.operand_a + ex.operand_b;
            ALU_SUB:  result = ex.operand_a - ex.operand_b;
            ALU_AND:  result = ex.operand_a & ex.operand_b;
            ALU_OR:   result = ex.operand_a | ex.operand_b;
            ALU_XOR:  result = ex.operand_a ^ ex.operand_b;
            ALU_NOR:  result = ~(ex.operand_a | ex.operand_b);
            ALU_SLT:  result = word_t'($signed(ex.operand_a) < $signed(ex.operand_b));
            ALU_SLTU: result = word_t'(ex.operand_a < ex.operand_b);
            ALU_SLL:  result = ex.operand_a << sh;
            ALU_SRL:  result = ex.operand_a >> sh;
            ALU_LUI:  result = {ex.operand_b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    assign do_write = ex.valid && ex.write_en;

    // result still in flight, picked up by decode
    assign fwd_en   = do_write;
    assign fwd_addr = ex.dest;
    assign fwd_data = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= do_write;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            wb_addr <= ex.dest;
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                  clk,
    input  wire                  rst,
    output logic                 imem_req,
    output mini_mips_pkg::word_t imem_addr,
    input  wire                  imem_ack,
    input  mini_mips_pkg::word_t imem_data,
    output logic                 instr_valid,
    output mini_mips_pkg::word_t instr
);
    import mini_mips_pkg::*;

    fetch_state_t state;
    word_t        pc;
    logic         capture;

    // req is held for the whole REQ phase, so addr follows pc directly
    assign imem_req  = (state == FETCH_REQ);
    assign imem_addr = pc;
    assign capture   = (state == FETCH_REQ) && imem_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= FETCH_IDLE;
            pc          <= RESET_PC;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            case (state)
                FETCH_IDLE: begin
                    state <= FETCH_REQ;
                end
                FETCH_REQ: begin
                    if (imem_ack) begin
                        state       <= FETCH_RELEASE;
                        pc          <= pc + PC_STEP;
                        instr_valid <= 1'b1;
                    end
                end
                FETCH_RELEASE: begin
                    // wait for the responder to drop ack
                    if (!imem_ack) begin
                        state <= FETCH_REQ;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            instr <= imem_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/mini_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mini_mips_core (
    input  wire                       clk,
    input  wire                       rst,
    output logic                      imem_req,
    output mini_mips_pkg::word_t      imem_addr,
    input  wire                       imem_ack,
    input  mini_mips_pkg::word_t      imem_data,
    output logic                      wb_valid,
    output mini_mips_pkg::reg_addr_t  wb_addr,
    output mini_mips_pkg::word_t      wb_data
);
    import mini_mips_pkg::*;

    logic      instr_valid;
    word_t     instr;
    logic      fwd_en;
    reg_addr_t fwd_addr;
    word_t     fwd_data;

    reg_read_bus rd_bus ();
    exec_bus     ex_bus ();

    fetch_stage u_fetch (
        .clk         (clk),
        .rst         (rst),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_ack    (imem_ack),
        .imem_data   (imem_data),
        .instr_valid (instr_valid),
        .instr       (instr)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd          (rd_bus.reader),
        .fwd_en      (fwd_en),
        .fwd_addr    (fwd_addr),
        .fwd_data    (fwd_data),
        .ex          (ex_bus.source)
    );

    // written from the write-back register
    reg_file u_reg_file (
        .clk   (clk),
        .rst   (rst),
        .rd    (rd_bus.file),
        .we    (wb_valid),
        .waddr (wb_addr),
        .wdata (wb_data)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst      (rst),
        .ex       (ex_bus.sink),
        .fwd_en   (fwd_en),
        .fwd_addr (fwd_addr),
        .fwd_data (fwd_data),
        .wb_valid (wb_valid),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

// File: hw/mini_mips_pkg.sv
`default_nettype none

package mini_mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  alu_op_t;

    typedef enum logic [1:0] {
        FETCH_REQ,
        FETCH_RELEASE,
        FETCH_IDLE
    } fetch_state_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_NOR  = 4'd5;
    localparam alu_op_t ALU_SLT  = 4'd6;
    localparam alu_op_t ALU_SLTU = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_LUI  = 4'd10;

    // primary opcode field
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // function field of R-type
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t PC_STEP  = 32'd4;

endpackage

`default_nettype wire

// File: hw/pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

// register file read ports, addresses out and data back in the same cycle
interface reg_read_bus;
    import mini_mips_pkg::*;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    modport reader (output rs_addr, output rt_addr, input rs_data, input rt_data);
    modport file (input rs_addr, input rt_addr, output rs_data, output rt_data);
endinterface

// decode/execute pipeline register contents
interface exec_bus;
    import mini_mips_pkg::*;

    logic      valid;
    alu_op_t   alu_op;
    reg_addr_t dest;
    logic      write_en;
    word_t     operand_a;
    word_t     operand_b;

    modport source (
        output valid, output alu_op, output dest,
        output write_en, output operand_a, output operand_b
    );
    modport sink (
        input valid, input alu_op, input dest,
        input write_en, input operand_a, input operand_b
    );
endinterface

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                       clk,
    input  wire                       rst,
    reg_read_bus.file                 rd,
    input  wire                       we,
    input  mini_mips_pkg::reg_addr_t  waddr,
    input  mini_mips_pkg::word_t      wdata
);
    import mini_mips_pkg::*;

    word_t regs [1:31];
    logic  wr_hit;

    assign wr_hit = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[waddr] <= wdata;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd.rs_data = (rd.rs_addr == '0) ? '0 :
                        (wr_hit && waddr == rd.rs_addr) ? wdata : regs[rd.rs_addr];
    assign rd.rt_data = (rd.rt_addr == '0) ? '0 :
                        (wr_hit && waddr == rd.rt_addr) ? wdata : regs[rd.rt_addr];

endmodule

`default_nettype wire

// File: mini_mips.f
hw/mini_mips_pkg.sv
hw/pipe_if.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mini_mips_core.sv
test/mini_mips_chk.sv
test/mini_mips_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the mini_mips testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module mini_mips_tb \
    -f mini_mips.f \
    -Mdir obj_dir -o mini_mips_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/mini_mips_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qxF '** PASS **' <<< "$output"; then
    exit 0
fi
exit 1

// File: test/mini_mips_chk.sv
`timescale 1ns/1ps
`default_nettype none

module mini_mips_chk (
    input wire                      clk,
    input wire                      rst,
    input wire                      imem_req,
    input mini_mips_pkg::word_t     imem_addr,
    input wire                      imem_ack,
    input wire                      wb_valid,
    input mini_mips_pkg::reg_addr_t wb_addr
);
    int fail_count = 0;

    // four-phase request side
    req_held: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_ack |=> imem_req)
        else begin
            fail_count++;
            $error("imem_req dropped before imem_ack");
        end

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        imem_req && !imem_ack |=> $stable(imem_addr))
        else begin
            fail_count++;
            $error("imem_addr changed during a request");
        end

    wb_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_addr != 5'd0)
        else begin
            fail_count++;
            $error("write-back to register zero");
        end

    req_after_rst: assert property (@(posedge clk) rst |=> !imem_req)
        else begin
            fail_count++;
            $error("imem_req high right after reset");
        end

endmodule

bind mini_mips_core mini_mips_chk u_chk (
    .clk       (clk),
    .rst       (rst),
    .imem_req  (imem_req),
    .imem_addr (imem_addr),
    .imem_ack  (imem_ack),
    .wb_valid  (wb_valid),
    .wb_addr   (wb_addr)
);

`default_nettype wire

// File: test/mini_mips_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mini_mips_tb;
    import mini_mips_pkg::*;

    localparam int          RANDOM_COUNT = 300;
    localparam int          WAIT_LIMIT   = 200;
    localparam int          WB_LATENCY   = 3;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

    logic        clk;
    logic        rst;
    logic        imem_req;
    word_t       imem_addr;
    logic        imem_ack;
    word_t       imem_data;
    logic        wb_valid;
    reg_addr_t   wb_addr;
    word_t       wb_data;

    logic [31:0] lfsr;
    word_t       prog [$];
    int          directed_len;
    word_t       model_regs [32];
    reg_addr_t   exp_addr [$];
    word_t       exp_data [$];
    int          exp_cycle [$];
    int          cyc = 0;
    int          errors;
    int          checks;
    int          writes;
    logic        fetch_done;

    mini_mips_core DUT (
        .clk       (clk),
        .rst       (rst),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // edge count, read 1 ns after each edge
    always @(posedge clk) cyc <= cyc + 1;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        errors++;
        $display("timeout: %s", what);
        $display("checks %0d, writes %0d, errors %0d", checks, writes, errors);
        $display("** FAIL **");
        $finish;
    endtask

    // galois form, one shift per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input reg_addr_t rd,
                                    input reg_addr_t rs, input reg_addr_t rt,
                                    input shamt_t sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rt,
                                    input reg_addr_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t random_instr();
        logic [31:0] k;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        word_t       ins;
        k   = next_bits(5) % 17;
        rs  = reg_addr_t'(next_bits(4));
        rt  = reg_addr_t'(next_bits(4));
        rd  = reg_addr_t'(next_bits(4));
        imm = 16'(next_bits(16));
        case (k)
            0:       ins = enc_r(FN_ADDU, rd, rs, rt, 5'd0);
            1:       ins = enc_r(FN_SUBU, rd, rs, rt, 5'd0);
            2:       ins = enc_r(FN_AND, rd, rs, rt, 5'd0);
            3:       ins = enc_r(FN_OR, rd, rs, rt, 5'd0);
            4:       ins = enc_r(FN_XOR, rd, rs, rt, 5'd0);
            5:       ins = enc_r(FN_NOR, rd, rs, rt, 5'd0);
            6:       ins = enc_r(FN_SLT, rd, rs, rt, 5'd0);
            7:       ins = enc_r(FN_SLTU, rd, rs, rt, 5'd0);
            8:       ins = enc_r(FN_SLL, rd, 5'd0, rt, shamt_t'(imm[4:0]));
            9:       ins = enc_r(FN_SRL, rd, 5'd0, rt, shamt_t'(imm[9:5]));
            10:      ins = enc_i(OP_ADDIU, rt, rs, imm);
            11:      ins = enc_i(OP_SLTI, rt, rs, imm);
            12:      ins = enc_i(OP_ANDI, rt, rs, imm);
            13:      ins = enc_i(OP_ORI, rt, rs, imm);
            14:      ins = enc_i(OP_XORI, rt, rs, imm);
            15:      ins = enc_i(OP_LUI, rt, 5'd0, imm);
            default: ins = {6'h23, rs, rt, imm};
        endcase
        return ins;
    endfunction

    // in-order model of one instruction against model_regs
    function automatic void model_instr(input word_t ins, output logic we,
                                        output reg_addr_t dest, output word_t val);
        word_t a;
        word_t b;
        word_t zimm;
        word_t simm;
        a    = model_regs[ins[25:21]];
        b    = model_regs[ins[20:16]];
        zimm = {16'h0000, ins[15:0]};
        simm = {{16{ins[15]}}, ins[15:0]};
        we   = 1'b1;
        dest = ins[20:16];
        val  = '0;
        case (ins[31:26])
            OP_RTYPE: begin
                dest = ins[15:11];
                case (ins[5:0])
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    FN_NOR:  val = ~(a | b);
                    FN_SLT:  val = {31'b0, $signed(a) < $signed(b)};
                    FN_SLTU: val = {31'b0, a < b};
                    FN_SLL:  val = b << ins[10:6];
                    FN_SRL:  val = b >> ins[10:6];
                    default: we = 1'b0;
                endcase
            end
            OP_ADDIU: val = a + simm;
            OP_SLTI:  val = {31'b0, $signed(a) < $signed(simm)};
            OP_ANDI:  val = a & zimm;
            OP_ORI:   val = a | zimm;
            OP_XORI:  val = a ^ zimm;
            OP_LUI:   val = {ins[15:0], 16'h0000};
            default:  we = 1'b0;
        endcase
        if (dest == '0) begin
            we = 1'b0;
        end
    endfunction

    task automatic build_program();
        logic [5:0] r_fns [10];
        logic [5:0] i_ops [6];
        shamt_t     sh;
        r_fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU,
                  FN_SLL, FN_SRL};
        i_ops = '{OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        // preload r1..r8
        for (int r = 1; r <= 8; r++) begin
            prog.push_back(enc_i(OP_LUI, reg_addr_t'(r), 5'd0, 16'(next_bits(16))));
            prog.push_back(enc_i(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), 16'(next_bits(16))));
        end
        foreach (r_fns[i]) begin
            sh = (i >= 8) ? 5'd13 : 5'd0;
            prog.push_back(enc_r(r_fns[i], reg_addr_t'(9 + i), reg_addr_t'(1 + i % 8),
                                 reg_addr_t'(8 - i % 8), sh));
        end
        // negative and positive immediates
        foreach (i_ops[j]) begin
            prog.push_back(enc_i(i_ops[j], reg_addr_t'(19 + 2 * j), reg_addr_t'(1 + j), 16'h8765));
            prog.push_back(enc_i(i_ops[j], reg_addr_t'(20 + 2 * j), reg_addr_t'(1 + j), 16'h1234));
        end
        // dependent chain
        prog.push_back(enc_r(FN_ADDU, 5'd20, 5'd1, 5'd2, 5'd0));
        prog.push_back(enc_r(FN_SUBU, 5'd21, 5'd20, 5'd3, 5'd0));
        prog.push_back(enc_i(OP_ADDIU, 5'd20, 5'd21, 16'hfff0));
        prog.push_back(enc_r(FN_XOR, 5'd22, 5'd20, 5'd21, 5'd0));
        prog.push_back(enc_r(FN_SLL, 5'd22, 5'd0, 5'd22, 5'd4));
        // no write expected for the next four
        prog.push_back(enc_r(FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
        prog.push_back(enc_i(OP_ORI, 5'd0, 5'd3, 16'hffff));
        prog.push_back(enc_r(6'h08, 5'd23, 5'd1, 5'd2, 5'd0));
        prog.push_back({6'h23, 5'd1, 5'd24, 16'h0010});
        prog.push_back(enc_r(FN_OR, 5'd25, 5'd0, 5'd0, 5'd0));
        prog.push_back(enc_i(OP_ADDIU, 5'd26, 5'd0, 16'h0005));
        directed_len = prog.size();
        repeat (RANDOM_COUNT) prog.push_back(random_instr());
    endtask

    task automatic run_responder();
        int        idle;
        int        delay;
        word_t     addr_seen;
        logic      we;
        reg_addr_t dest;
        word_t     val;
        for (int i = 0; i < prog.size(); i++) begin
            idle = 0;
            while (!imem_req) begin
                next_cycle();
                idle++;
                if (idle > WAIT_LIMIT) abort_run("fetch request never arrived");
            end
            if (i == 0) check_value("first imem_req delay", idle, 1);
            check_value("imem_addr", imem_addr, RESET_PC + PC_STEP * i);
            addr_seen = imem_addr;
            delay = (i < directed_len) ? 0 : int'(next_bits(2));
            repeat (delay) begin
                next_cycle();
                check_value("imem_req", word_t'(imem_req), 32'd1);
                check_value("imem_addr", imem_addr, addr_seen);
            end
            imem_ack  = 1'b1;
            imem_data = prog[i];
            next_cycle();
            // this edge captured the word
            model_instr(prog[i], we, dest, val);
            if (we) begin
                model_regs[dest] = val;
                exp_addr.push_back(dest);
                exp_data.push_back(val);
                exp_cycle.push_back(cyc);
            end
            idle = 0;
            while (imem_req) begin
                next_cycle();
                idle++;
                if (idle > WAIT_LIMIT) abort_run("imem_req stayed high after ack");
            end
            imem_ack  = 1'b0;
            imem_data = word_t'(next_bits(32));
        end
        fetch_done = 1'b1;
    endtask

    task automatic watch_writebacks();
        forever begin
            next_cycle();
            if (wb_valid) begin
                if (exp_addr.size() == 0) begin
                    errors++;
                    $display("unexpected write of 0x%08h to r%0d", wb_data, wb_addr);
                end else begin
                    writes++;
                    check_value("wb_addr", word_t'(wb_addr), word_t'(exp_addr.pop_front()));
                    check_value("wb_data", wb_data, exp_data.pop_front());
                    // seen 1 ns after edge cyc, so sampled at the next edge
                    check_value("wb latency", cyc + 1 - exp_cycle.pop_front(), WB_LATENCY);
                end
            end
        end
    endtask

    initial begin
        int idle;
        rst        = 1'b1;
        imem_ack   = 1'b0;
        imem_data  = '0;
        lfsr       = 32'h0d154ce0;
        errors     = 0;
        checks     = 0;
        writes     = 0;
        fetch_done = 1'b0;
        foreach (model_regs[i]) model_regs[i] = '0;
        build_program();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            run_responder();
            watch_writebacks();
        join_none
        idle = 0;
        while (!fetch_done || exp_addr.size() != 0) begin
            next_cycle();
            idle++;
            if (idle > 16 * prog.size()) abort_run("program never drained");
        end
        // stray writes would show up here
        repeat (10) next_cycle();
        errors += DUT.u_chk.fail_count;
        $display("checks %0d, writes %0d, errors %0d", checks, writes, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
